// ==== logic/alu_pkg.sv ====
// ALU coprocessor shared definitions

package alu_pkg;

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] data_t;  // operand or result word
    typedef logic [2:0]        width_t; // one-hot: byte, word, long
    typedef logic [7:0]        flags_t; // S Z 0 H 0 V N C
    typedef logic [4:0]        paddr_t; // apb byte address

    typedef enum logic [5:0] {
        ALU_MOVE = 6'd0,
        ALU_ADD  = 6'd1,
        ALU_ADC  = 6'd2,
        ALU_SUB  = 6'd3,
        ALU_SBC  = 6'd4,
        ALU_CP   = 6'd5,
        ALU_AND  = 6'd6,
        ALU_OR   = 6'd7,
        ALU_XOR  = 6'd8,
        ALU_CPL  = 6'd9,
        ALU_CCF  = 6'd10,
        ALU_DJNZ = 6'd11,
        ALU_EXTS = 6'd12,
        ALU_EXTZ = 6'd13,
        ALU_BS1F = 6'd14,
        ALU_BS1B = 6'd15
    } alu_op_t;

    localparam width_t W_BYTE = 3'b001;
    localparam width_t W_WORD = 3'b010;
    localparam width_t W_LONG = 3'b100;

    // flag byte bit positions
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;
    localparam int FLAG_V = 2; // overflow or parity
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 0;

    // register map
    localparam paddr_t REG_OP0    = 5'h00;
    localparam paddr_t REG_OP1    = 5'h04;
    localparam paddr_t REG_IMM    = 5'h08;
    localparam paddr_t REG_CMD    = 5'h0C;
    localparam paddr_t REG_RESULT = 5'h10;
    localparam paddr_t REG_STATUS = 5'h14;

    // command word fields
    localparam int CMD_SEL_LSB   = 0;
    localparam int CMD_SEL_MSB   = 5;
    localparam int CMD_WIDTH_LSB = 8;
    localparam int CMD_WIDTH_MSB = 10;
    localparam int CMD_SEL_IMM   = 12;
    localparam int CMD_FLAG_ONLY = 13;

    // status word fields
    localparam int STAT_FLAGS_LSB = 0;
    localparam int STAT_FLAGS_MSB = 7;
    localparam int STAT_DJNZ      = 8;
    localparam int STAT_DONE      = 16;

endpackage

// ==== logic/alu_apb_regs.sv ====
// ALU coprocessor APB register block

`timescale 1ns/1ps

module alu_apb_regs (
    input  logic             clk,
    input  logic             rst,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  alu_pkg::paddr_t  paddr,
    input  alu_pkg::data_t   pwdata,
    output alu_pkg::data_t   prdata,
    output logic             pready,
    output logic             pslverr,
    input  alu_pkg::data_t   result,
    input  alu_pkg::flags_t  status_flags,
    input  logic             status_djnz,
    input  logic             done,
    output alu_pkg::data_t   op0,
    output alu_pkg::data_t   op1,
    output alu_pkg::data_t   imm,
    output alu_pkg::alu_op_t sel,
    output logic             sel_imm,
    output alu_pkg::width_t  width,
    output logic             flag_only,
    output logic             issue
);

    import alu_pkg::*;

    logic  access;
    logic  addr_ok;
    logic  ro_hit;
    logic  cmd_hit;
    logic  cmd_ok;
    logic  err;
    logic  wr_ok;
    data_t cmd_q;   // last accepted command word
    data_t status;

    assign access  = psel & penable;
    assign addr_ok = paddr inside {REG_OP0, REG_OP1, REG_IMM, REG_CMD, REG_RESULT, REG_STATUS};
    assign ro_hit  = (paddr == REG_RESULT) || (paddr == REG_STATUS);
    assign cmd_hit = paddr == REG_CMD;

    // only kept opcodes and a one-hot width may start the ALU
    assign cmd_ok = (pwdata[CMD_SEL_MSB:CMD_SEL_LSB] inside {
                        ALU_MOVE, ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP,
                        ALU_AND, ALU_OR, ALU_XOR, ALU_CPL, ALU_CCF, ALU_DJNZ,
                        ALU_EXTS, ALU_EXTZ, ALU_BS1F, ALU_BS1B})
                    && $onehot(pwdata[CMD_WIDTH_MSB:CMD_WIDTH_LSB]);

    assign err = access & (~addr_ok | (pwrite & ro_hit) | (pwrite & cmd_hit & ~cmd_ok));
    assign wr_ok = access & pwrite & ~err;

    assign pready  = 1'b1; // no wait states
    assign pslverr = err;

    // operand registers
    always_ff @(posedge clk) begin
        if (wr_ok && paddr == REG_OP0) op0 <= pwdata;
        if (wr_ok && paddr == REG_OP1) op1 <= pwdata;
        if (wr_ok && paddr == REG_IMM) imm <= pwdata;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_q <= '0;
            issue <= 1'b0;
        end else begin
            issue <= wr_ok & cmd_hit; // one cycle after the access
            if (wr_ok && cmd_hit) begin
                cmd_q <= pwdata;
            end
        end
    end

    assign sel       = alu_op_t'(cmd_q[CMD_SEL_MSB:CMD_SEL_LSB]);
    assign width     = cmd_q[CMD_WIDTH_MSB:CMD_WIDTH_LSB];
    assign sel_imm   = cmd_q[CMD_SEL_IMM];
    assign flag_only = cmd_q[CMD_FLAG_ONLY];

    always_comb begin
        status = '0;
        status[STAT_FLAGS_MSB:STAT_FLAGS_LSB] = status_flags;
        status[STAT_DJNZ] = status_djnz;
        status[STAT_DONE] = done;
    end

    // read mux
    always_comb begin
        case (paddr)
            REG_OP0:    prdata = op0;
            REG_OP1:    prdata = op1;
            REG_IMM:    prdata = imm;
            REG_CMD:    prdata = cmd_q;
            REG_RESULT: prdata = result;
            REG_STATUS: prdata = status;
            default:    prdata = '0;
        endcase
    end

endmodule

// ==== logic/alu_core.sv ====
// Width-aware 32-bit ALU

`timescale 1ns/1ps

module alu_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  alu_pkg::data_t   op0,       // destination
    input  alu_pkg::data_t   op1,       // source
    input  alu_pkg::data_t   imm,       // alternative source
    input  alu_pkg::alu_op_t sel,
    input  logic             sel_imm,
    input  alu_pkg::width_t  width,
    input  logic             flag_only,
    output alu_pkg::data_t   dout,
    output alu_pkg::flags_t  flags,
    output logic             djnz,
    output logic             result_we,
    output logic             flag_we
);

    import alu_pkg::*;

    data_t       op2;
    data_t       rslt;
    data_t       sum;
    flags_t      nx_flags;
    logic        nx_djnz;
    logic        is_sub;
    logic        cin;
    logic        hc;
    logic [2:0]  cc;      // carries out of bits 7, 15, 31
    logic [32:0] ext_a;
    logic [32:0] ext_b;
    logic [32:0] ext_r;

    function automatic logic msb_at(data_t x, width_t w);
        case (w)
            W_BYTE:  return x[7];
            W_WORD:  return x[15];
            default: return x[31];
        endcase
    endfunction

    function automatic logic zero_at(data_t x, width_t w);
        case (w)
            W_BYTE:  return x[7:0] == '0;
            W_WORD:  return x[15:0] == '0;
            default: return x == '0;
        endcase
    endfunction

    function automatic logic carry_at(logic [2:0] c, width_t w);
        case (w)
            W_BYTE:  return c[0];
            W_WORD:  return c[1];
            default: return c[2];
        endcase
    endfunction

    function automatic logic [32:0] sext(data_t x, width_t w);
        case (w)
            W_BYTE:  return {{25{x[7]}}, x[7:0]};
            W_WORD:  return {{17{x[15]}}, x[15:0]};
            default: return {x[31], x};
        endcase
    endfunction

    // even parity, 1 when the number of ones is even
    function automatic logic even_par(data_t x, width_t w);
        return (w == W_BYTE) ? ~^x[7:0] : ~^x[15:0];
    endfunction

    function automatic data_t scan_fwd(logic [15:0] x);
        data_t idx;
        idx = '0;
        for (int i = 15; i >= 0; i--) begin
            if (x[i]) idx = data_t'(i); // lowest set bit wins
        end
        return idx;
    endfunction

    function automatic data_t scan_back(logic [15:0] x);
        data_t idx;
        idx = '0;
        for (int i = 0; i < 16; i++) begin
            if (x[i]) idx = data_t'(i); // highest set bit wins
        end
        return idx;
    endfunction

    assign op2    = sel_imm ? imm : op1;
    assign is_sub = sel inside {ALU_SUB, ALU_SBC, ALU_CP};
    assign cin    = (sel == ALU_ADC || sel == ALU_SBC) ? flags[FLAG_C] : 1'b0;
    assign ext_a  = sext(op0, width);
    assign ext_b  = sext(op2, width);

    always_comb begin
        rslt     = dout;  // untouched bits hold
        nx_flags = flags;
        nx_djnz  = djnz;
        sum      = '0;
        hc       = 1'b0;
        cc       = '0;
        ext_r    = '0;
        case (sel)
            ALU_MOVE: rslt = op2;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                // nibble and byte chain gives half carry and width carries
                if (is_sub) begin
                    {hc, sum[3:0]}     = {1'b0, op0[3:0]} - {1'b0, op2[3:0]} - {4'd0, cin};
                    {cc[0], sum[7:4]}  = {1'b0, op0[7:4]} - {1'b0, op2[7:4]} - {4'd0, hc};
                    {cc[1], sum[15:8]} = {1'b0, op0[15:8]} - {1'b0, op2[15:8]} - {8'd0, cc[0]};
                    {cc[2], sum[31:16]} = {1'b0, op0[31:16]} - {1'b0, op2[31:16]}
                                          - {16'd0, cc[1]};
                    ext_r = ext_a - ext_b - {32'd0, cin};
                end else begin
                    {hc, sum[3:0]}     = {1'b0, op0[3:0]} + {1'b0, op2[3:0]} + {4'd0, cin};
                    {cc[0], sum[7:4]}  = {1'b0, op0[7:4]} + {1'b0, op2[7:4]} + {4'd0, hc};
                    {cc[1], sum[15:8]} = {1'b0, op0[15:8]} + {1'b0, op2[15:8]} + {8'd0, cc[0]};
                    {cc[2], sum[31:16]} = {1'b0, op0[31:16]} + {1'b0, op2[31:16]}
                                          + {16'd0, cc[1]};
                    ext_r = ext_a + ext_b + {32'd0, cin};
                end
                if (sel != ALU_CP) rslt = sum; // compare only sets flags
                nx_flags[FLAG_S] = msb_at(sum, width);
                nx_flags[FLAG_Z] = zero_at(sum, width);
                nx_flags[FLAG_H] = hc;
                nx_flags[FLAG_V] = ext_r[32] ^ msb_at(sum, width);
                nx_flags[FLAG_N] = is_sub;
                nx_flags[FLAG_C] = carry_at(cc, width);
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                if (sel == ALU_AND) rslt = op0 & op2;
                else if (sel == ALU_OR) rslt = op0 | op2;
                else rslt = op0 ^ op2;
                nx_flags[FLAG_S] = msb_at(rslt, width);
                nx_flags[FLAG_Z] = zero_at(rslt, width);
                nx_flags[FLAG_H] = sel == ALU_AND;
                nx_flags[FLAG_V] = even_par(rslt, width);
                nx_flags[FLAG_N] = 1'b0;
                nx_flags[FLAG_C] = 1'b0;
            end
            ALU_CPL: begin
                rslt = ~op2;
                nx_flags[FLAG_H] = 1'b1;
                nx_flags[FLAG_N] = 1'b1;
            end
            ALU_CCF: begin
                nx_flags[FLAG_C] = ~flags[FLAG_C];
                nx_flags[FLAG_N] = 1'b0;
            end
            ALU_DJNZ: begin
                if (width == W_BYTE) begin
                    rslt[7:0] = op0[7:0] - 8'd1;
                    nx_djnz   = rslt[7:0] == '0;
                end else begin
                    rslt[15:0] = op0[15:0] - 16'd1;
                    nx_djnz    = rslt[15:0] == '0;
                end
            end
            ALU_EXTS: begin
                if (width == W_WORD) rslt[15:0] = {{8{op0[7]}}, op0[7:0]};
                else if (width == W_LONG) rslt = {{16{op0[15]}}, op0[15:0]};
            end
            ALU_EXTZ: begin
                if (width == W_WORD) rslt[15:0] = {8'd0, op0[7:0]};
                else if (width == W_LONG) rslt = {16'd0, op0[15:0]};
            end
            ALU_BS1F: begin
                rslt = scan_fwd(op1[15:0]);
                nx_flags[FLAG_V] = op1[15:0] == '0;
            end
            ALU_BS1B: begin
                rslt = scan_back(op1[15:0]);
                nx_flags[FLAG_V] = op1[15:0] == '0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            flags     <= '0;
            djnz      <= 1'b0;
            result_we <= 1'b0;
            flag_we   <= 1'b0;
        end else begin
            result_we <= issue & ~flag_only;
            flag_we   <= issue;
            if (issue) begin
                flags <= nx_flags;
                djnz  <= nx_djnz;
                if (!flag_only) dout <= rslt;
            end
        end
    end

    // register block only issues checked commands
    a_width_onehot: assert property (@(posedge clk) disable iff (rst)
        issue |-> $onehot(width));

endmodule

// ==== logic/alu_result_latch.sv ====
// ALU result and status holding registers

`timescale 1ns/1ps

module alu_result_latch (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue,
    input  logic            result_we,
    input  logic            flag_we,
    input  alu_pkg::data_t  dout,
    input  alu_pkg::flags_t flags,
    input  logic            djnz,
    output alu_pkg::data_t  result,
    output alu_pkg::flags_t status_flags,
    output logic            status_djnz,
    output logic            done
);

    import alu_pkg::*;

    logic busy; // a command is in the core pipeline

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result       <= '0;
            status_flags <= '0;
            status_djnz  <= 1'b0;
        end else begin
            if (result_we) result <= dout;
            if (flag_we) begin
                status_flags <= flags;
                status_djnz  <= djnz;
            end
        end
    end

    // a new issue overrides the write-back of the previous one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
            busy <= 1'b0;
        end else if (issue) begin
            done <= 1'b0;
            busy <= 1'b1;
        end else if (flag_we) begin
            done <= 1'b1;
            busy <= 1'b0;
        end
    end

    // write-back always belongs to an earlier issue
    a_wb_outstanding: assert property (@(posedge clk) disable iff (rst)
        (issue && flag_we && !done) |-> busy);

    // core never writes a result without its flags
    a_result_with_flags: assert property (@(posedge clk) disable iff (rst)
        $rose(result_we) |-> flag_we);

endmodule

// ==== logic/alu_apb_top.sv ====
// APB ALU coprocessor top level

`timescale 1ns/1ps

module alu_apb_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  alu_pkg::paddr_t paddr,
    input  alu_pkg::data_t  pwdata,
    output alu_pkg::data_t  prdata,
    output logic            pready,
    output logic            pslverr
);

    import alu_pkg::*;

    data_t   op0;
    data_t   op1;
    data_t   imm;
    alu_op_t sel;
    logic    sel_imm;
    width_t  width;
    logic    flag_only;
    logic    issue;
    data_t   dout;
    flags_t  flags;
    logic    djnz;
    logic    result_we;
    logic    flag_we;
    data_t   result;
    flags_t  status_flags;
    logic    status_djnz;
    logic    done;

    alu_apb_regs u_regs (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .result, .status_flags, .status_djnz, .done,
        .op0, .op1, .imm, .sel, .sel_imm, .width, .flag_only, .issue
    );

    alu_core u_core (
        .clk, .rst, .issue, .op0, .op1, .imm, .sel, .sel_imm, .width, .flag_only,
        .dout, .flags, .djnz, .result_we, .flag_we
    );

    alu_result_latch u_latch (
        .clk, .rst, .issue, .result_we, .flag_we, .dout, .flags, .djnz,
        .result, .status_flags, .status_djnz, .done
    );

endmodule

// ==== verif/alu_model.svh ====
// ALU reference model
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

data_t  exp_result; // mirrors the held result word
flags_t exp_flags;
logic   exp_djnz;

function automatic logic bit_of(longint unsigned v, int i);
    return ((v >> i) & 64'h1) != 64'h0;
endfunction

task automatic model_exec(input alu_op_t op, input width_t w, input data_t a,
                          input data_t src, input data_t imm_val, input logic use_imm,
                          input logic no_result);
    longint unsigned mask, ua, ub, full, nib, ci;
    longint sa, sb, sr, lim;
    int top;
    int idx;
    logic sub;
    data_t b, r, sum, pm;
    flags_t f;
    b = use_imm ? imm_val : src;
    top = (w == W_BYTE) ? 7 : (w == W_WORD) ? 15 : 31;
    mask = (64'd1 << (top + 1)) - 64'd1;
    lim = longint'(64'd1 << top);
    ci = (op == ALU_ADC || op == ALU_SBC) ? 64'(exp_flags[FLAG_C]) : 64'd0;
    r = exp_result;
    f = exp_flags;
    idx = 0;
    case (op)
        ALU_MOVE: r = b;
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
            sub = op inside {ALU_SUB, ALU_SBC, ALU_CP};
            ua = 64'(a) & mask;
            ub = 64'(b) & mask;
            full = sub ? ua - ub - ci : ua + ub + ci; // carry or borrow lands above top
            nib = sub ? (64'(a) & 64'hf) - (64'(b) & 64'hf) - ci
                      : (64'(a) & 64'hf) + (64'(b) & 64'hf) + ci;
            sa = bit_of(ua, top) ? longint'(ua) - longint'(mask) - 64'sd1 : longint'(ua);
            sb = bit_of(ub, top) ? longint'(ub) - longint'(mask) - 64'sd1 : longint'(ub);
            sr = sub ? sa - sb - longint'(ci) : sa + sb + longint'(ci);
            sum = sub ? a - b - data_t'(ci) : a + b + data_t'(ci); // whole word written
            if (op != ALU_CP) r = sum;
            f[FLAG_S] = bit_of(64'(sum), top);
            f[FLAG_Z] = (64'(sum) & mask) == 64'd0;
            f[FLAG_H] = bit_of(nib, 4);
            f[FLAG_V] = (sr >= lim) || (sr < -lim);
            f[FLAG_N] = sub;
            f[FLAG_C] = bit_of(full, top + 1);
        end
        ALU_AND, ALU_OR, ALU_XOR: begin
            r = (op == ALU_AND) ? (a & b) : (op == ALU_OR) ? (a | b) : (a ^ b);
            pm = (w == W_BYTE) ? 32'hff : 32'hffff;
            f[FLAG_S] = bit_of(64'(r), top);
            f[FLAG_Z] = (64'(r) & mask) == 64'd0;
            f[FLAG_H] = op == ALU_AND;
            f[FLAG_V] = ($countones(r & pm) % 2) == 0; // even parity
            f[FLAG_N] = 1'b0;
            f[FLAG_C] = 1'b0;
        end
        ALU_CPL: begin
            r = ~b;
            f[FLAG_H] = 1'b1;
            f[FLAG_N] = 1'b1;
        end
        ALU_CCF: begin
            f[FLAG_C] = ~exp_flags[FLAG_C];
            f[FLAG_N] = 1'b0;
        end
        ALU_DJNZ: begin
            if (w == W_BYTE) begin
                r[7:0] = a[7:0] - 8'd1;
                exp_djnz = r[7:0] == 8'd0;
            end else begin
                r[15:0] = a[15:0] - 16'd1;
                exp_djnz = r[15:0] == 16'd0;
            end
        end
        ALU_EXTS: begin
            if (w == W_WORD) r[15:0] = {{8{a[7]}}, a[7:0]};
            if (w == W_LONG) r = {{16{a[15]}}, a[15:0]};
        end
        ALU_EXTZ: begin
            if (w == W_WORD) r[15:0] = {8'd0, a[7:0]};
            if (w == W_LONG) r = {16'd0, a[15:0]};
        end
        ALU_BS1F, ALU_BS1B: begin
            // scan op1 only, the immediate is never used here
            for (int i = 0; i < 16; i++) begin
                if (op == ALU_BS1B && bit_of(64'(src), i)) idx = i;
                if (op == ALU_BS1F && bit_of(64'(src), 15 - i)) idx = 15 - i;
            end
            r = data_t'(idx);
            f[FLAG_V] = src[15:0] == 16'h0;
        end
        default: ;
    endcase
    exp_flags = f;
    if (!no_result) exp_result = r;
endtask

`endif

// ==== verif/alu_tb.sv ====
// ALU coprocessor testbench

`timescale 1ns/1ps

module alu_tb;

    import alu_pkg::*;

    localparam int PERIOD   = 40;
    localparam int POLL_MAX = 20; // status reads before giving up

    logic   clk;
    logic   rst;
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    data_t  pwdata;
    data_t  prdata;
    logic   pready;
    logic   pslverr;
    integer seed;
    data_t  last_op0; // operand and command words last written
    data_t  last_op1;
    data_t  last_imm;
    data_t  last_cmd;

    alu_op_t arith_ops[5] = '{ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP};
    alu_op_t logic_ops[6] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_CPL, ALU_CCF, ALU_MOVE};
    alu_op_t misc_ops[4]  = '{ALU_EXTS, ALU_EXTZ, ALU_BS1F, ALU_BS1B};

    `include "alu_model.svh"

    alu_apb_top alu_apb_top_i (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input data_t exp, input data_t act);
        assert (act === exp) else
            fail_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
    endtask

    function automatic data_t rnd();
        return data_t'($random(seed));
    endfunction

    function automatic logic coin();
        data_t r;
        r = rnd();
        return r[0];
    endfunction

    function automatic int below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic width_t pick_width();
        return width_t'(3'b001 << below(3));
    endfunction

    function automatic data_t cmd_word(alu_op_t op, width_t w, logic use_imm, logic fo);
        return {18'd0, fo, use_imm, 1'b0, w, 2'b00, op};
    endfunction

    function automatic data_t status_word(logic d);
        return {15'd0, d, 7'd0, exp_djnz, exp_flags};
    endfunction

    // setup cycle, then access cycle, sampled mid low phase
    task automatic transfer(input logic wr, input paddr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(PERIOD / 4);
        check_hex("pready", 32'h1, data_t'(pready));
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_reg(input paddr_t addr, input data_t data, input logic exp_err);
        data_t unused;
        logic err;
        transfer(1'b1, addr, data, unused, err);
        check_hex("pslverr", data_t'(exp_err), data_t'(err));
    endtask

    task automatic read_reg(input paddr_t addr, output data_t data);
        logic err;
        transfer(1'b0, addr, '0, data, err);
        check_hex("pslverr", 32'h0, data_t'(err));
    endtask

    task automatic wait_done();
        data_t st;
        int n;
        st = '0;
        n = 0;
        while (n < POLL_MAX && !st[STAT_DONE]) begin
            read_reg(REG_STATUS, st);
            n++;
        end
        assert (st[STAT_DONE]) else
            fail_run("done never rose after a command was issued");
    endtask

    task automatic run_cmd(input alu_op_t op, input width_t w, input data_t a,
                           input data_t b, input data_t iv, input logic use_imm,
                           input logic fo);
        data_t rd;
        write_reg(REG_OP0, a, 1'b0);
        write_reg(REG_OP1, b, 1'b0);
        write_reg(REG_IMM, iv, 1'b0);
        write_reg(REG_CMD, cmd_word(op, w, use_imm, fo), 1'b0);
        last_op0 = a;
        last_op1 = b;
        last_imm = iv;
        last_cmd = cmd_word(op, w, use_imm, fo);
        model_exec(op, w, a, b, iv, use_imm, fo);
        wait_done();
        read_reg(REG_RESULT, rd);
        check_hex("result", exp_result, rd);
        read_reg(REG_STATUS, rd);
        check_hex("status", status_word(1'b1), rd);
    endtask

    initial begin
        data_t rd;
        data_t a;
        width_t w;
        int cnt;
        seed = 32'hbfef;
        clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        exp_result = '0;
        exp_flags = '0;
        exp_djnz = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_reg(REG_RESULT, rd);
        check_hex("result", 32'h0, rd);
        read_reg(REG_STATUS, rd);
        check_hex("status", status_word(1'b0), rd);

        repeat (40) begin // carry flows from one command to the next
            run_cmd(arith_ops[below(5)], pick_width(), rnd(), rnd(), rnd(), coin(), 1'b0);
        end
        repeat (40) begin
            run_cmd(logic_ops[below(6)], pick_width(), rnd(), rnd(), rnd(), coin(),
                    below(4) == 0);
        end

        // djnz countdown in byte and then word width
        for (int round = 0; round < 2; round++) begin
            w = (round == 0) ? W_BYTE : W_WORD;
            cnt = 1 + below(6);
            a = rnd();
            if (round == 0) a[7:0] = 8'(cnt);
            else a[15:0] = 16'(cnt);
            repeat (cnt) begin
                run_cmd(ALU_DJNZ, w, a, rnd(), rnd(), 1'b0, 1'b0);
                a = exp_result;
            end
            read_reg(REG_STATUS, rd);
            check_hex("status_djnz", 32'h1, data_t'(rd[STAT_DJNZ]));
        end

        repeat (16) begin
            run_cmd(misc_ops[below(4)], pick_width(), rnd(), rnd(), rnd(), coin(), 1'b0);
        end
        a = rnd();
        a[15:0] = 16'h0; // empty scan field
        run_cmd(ALU_BS1F, W_WORD, rnd(), a, rnd(), 1'b0, 1'b0);
        run_cmd(ALU_BS1B, W_LONG, rnd(), a, rnd(), 1'b0, 1'b0);

        write_reg(5'h18, rnd(), 1'b1);
        write_reg(5'h02, rnd(), 1'b1);
        write_reg(REG_RESULT, rnd(), 1'b1);
        write_reg(REG_STATUS, rnd(), 1'b1);
        write_reg(REG_CMD, 32'h0000_0128, 1'b1); // unused code
        write_reg(REG_CMD, 32'h0000_013f, 1'b1);
        write_reg(REG_CMD, 32'h0000_0301, 1'b1); // two width bits
        write_reg(REG_CMD, 32'h0000_0001, 1'b1); // no width bit
        read_reg(REG_RESULT, rd);
        check_hex("result", exp_result, rd);
        read_reg(REG_STATUS, rd);
        check_hex("status", status_word(1'b1), rd);
        read_reg(REG_OP0, rd);
        check_hex("op0", last_op0, rd);
        read_reg(REG_OP1, rd);
        check_hex("op1", last_op1, rd);
        read_reg(REG_IMM, rd);
        check_hex("imm", last_imm, rd);
        read_reg(REG_CMD, rd);
        check_hex("cmd", last_cmd, rd);

        $display("Test passed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
logic/alu_pkg.sv
logic/alu_apb_regs.sv
logic/alu_core.sv
logic/alu_result_latch.sv
logic/alu_apb_top.sv
verif/alu_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f files.f --top-module alu_tb \
		-Mdir obj_dir -o alu_tb

run: compile
	./obj_dir/alu_tb

clean:
	rm -rf obj_dir
